// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns -j 0
TOP       = masel_tb
FLIST     = masel_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/masel_tb.sv ====
// Testbench for the microaddress selector with trace playback and address compare
`timescale 1ns/1ns

module masel_tb;

  localparam int CLK_HALF_NS  = 20;   // 40 ns period
  localparam int RST_CYCLES   = 16;
  localparam int RST_WAIT_MAX = 64;   // Wakeups before reset wait gives up
  localparam int TRACE_MAX    = 1024; // File lines before trace wait gives up

  logic              s_mclk;
  logic              arst_n;
  masel_pkg::sel_t   sel;
  logic              cond;
  masel_pkg::uaddr_t jaddr;
  masel_pkg::uaddr_t ma;

  int n_checks   = 0; // Addresses compared
  int n_mismatch = 0; // Wrong addresses
  int n_other    = 0; // File, format and timeout problems

  masel_top u_dut (
    .s_mclk (s_mclk),
    .arst_n (arst_n),
    .sel    (sel),
    .cond   (cond),
    .jaddr  (jaddr),
    .ma     (ma)
  );

  // Free running clock, first rise at 20 ns
  initial begin
    s_mclk = 1'b0;
    forever #(CLK_HALF_NS) s_mclk = ~s_mclk;
  end

  // Reset over 16 rising edges
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge s_mclk);
    @(negedge s_mclk);
    arst_n = 1'b1; // Released on a falling edge
  end

  // One microaddress compare
  // Line 0 stands for the reset value
  task automatic check_ma(input masel_pkg::uaddr_t got,
                          input masel_pkg::uaddr_t want,
                          input int                line_no);
    n_checks++;
    if (got !== want) begin
      n_mismatch++;
      $display("[FAIL] ma at trace line %0d: got %h, expected %h", line_no, got, want);
    end
  endtask

  // Returns with the clock low and ma still at its reset value
  task automatic wait_reset_release(output bit released);
    int wakeups;
    wakeups = 0;
    while (arst_n !== 1'b1 && wakeups < RST_WAIT_MAX) begin
      @(negedge s_mclk or posedge arst_n);
      wakeups++;
    end
    released = (arst_n === 1'b1);
    if (!released) begin
      $display("Reset was not released within %0d clock edges", RST_WAIT_MAX);
    end
  endtask

  // Blank lines and // comments carry no step
  function automatic bit has_data(input string text);
    byte c;
    bit  found;
    bit  decided;
    found   = 1'b0;
    decided = 1'b0;
    for (int i = 0; i < text.len() && !decided; i++) begin
      c = text[i];
      if (c != " " && c != "\t") begin
        decided = 1'b1; // First visible character decides
        found   = (c != "/") && (c != "\n") && (c != "\r");
      end
    end
    return found;
  endfunction

  // Step through the trace
  // Drive at one falling edge, compare ma at the next
  task automatic play_trace(input int fd);
    string             text;
    int                line_no;
    int                n_steps;
    int                fields;
    logic [2:0]        sel_code;
    logic              cond_bit;
    masel_pkg::uaddr_t jump_addr;
    masel_pkg::uaddr_t want_ma;
    bit                at_end;
    line_no = 0;
    n_steps = 0;
    at_end  = 1'b0;
    while (!at_end && line_no < TRACE_MAX) begin
      if ($fgets(text, fd) == 0) begin
        at_end = 1'b1;
      end else begin
        line_no++;
        if (has_data(text)) begin
          fields = $sscanf(text, "%h %h %h %h", sel_code, cond_bit, jump_addr, want_ma);
          if (fields != 4) begin
            n_other++;
            $display("Trace line %0d holds %0d fields instead of 4", line_no, fields);
          end else begin
            sel   = masel_pkg::sel_t'(sel_code);
            cond  = cond_bit;
            jaddr = jump_addr;
            @(negedge s_mclk); // One rising edge in between
            check_ma(ma, want_ma, line_no);
            n_steps++;
          end
        end
      end
    end
    if (!at_end) begin
      n_other++;
      $display("Trace did not end within %0d lines", TRACE_MAX);
    end
    if (n_steps == 0) begin
      n_other++;
      $display("Trace file holds no steps");
    end
  endtask

  // Closing line, verdict, end of run
  task automatic report_and_finish();
    $display("Checked %0d addresses, %0d mismatches, %0d other errors",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0 && n_checks > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin : main
    int fd;
    bit released;
    sel   = masel_pkg::SEL_NEXT; // Keeps all strobes low in reset
    cond  = 1'b0;
    jaddr = '0;
    fd = $fopen("bench/masel_trace.txt", "r");
    if (fd == 0) begin
      n_other++;
      $display("Cannot open the trace file bench/masel_trace.txt");
    end else begin
      wait_reset_release(released);
      if (!released) begin
        n_other++;
      end else begin
        check_ma(ma, '0, 0); // Start of microprogram
        play_trace(fd);
      end
      $fclose(fd);
    end
    report_and_finish();
  end

endmodule

// ==== bench/masel_trace.txt ====
// Columns: sel cond jaddr expected_ma, all hex, one clock per line
// sel: 0 next, 1 jump, 2 jcond, 3 call, 4 ret, 5 hold, 6 rpt_set, 7 rpt_loop
// Count up from reset
0 0 0000 0001
0 0 0000 0002
0 0 0000 0003
// Wrap at the top of the address space
1 0 1ffe 1ffe
0 0 0000 1fff
0 0 0000 0000
0 0 0000 0001
// Jumps, conditional jumps and hold
2 1 0100 0100
2 0 0200 0101
5 0 0333 0101
5 1 0444 0101
2 1 0200 0200
1 1 0abc 0abc
0 1 0000 0abd
// Nested calls and returns
3 0 0400 0400
0 0 0000 0401
3 0 0500 0500
3 0 0600 0600
0 0 0000 0601
4 0 0000 0501
4 0 0000 0402
0 0 0000 0403
4 0 0000 0abe
// Five calls deep, the oldest return address is overwritten
3 0 0800 0800
3 0 0810 0810
3 0 0820 0820
3 0 0830 0830
3 0 0840 0840
4 0 0000 0831
4 0 0000 0821
4 0 0000 0811
4 0 0000 0801
4 0 0000 0831
// Loop count 3 over a two-word body
6 0 0003 0832
0 0 0000 0833
7 0 0000 0832
0 0 0000 0833
7 0 0000 0832
0 0 0000 0833
7 0 0000 0832
0 0 0000 0833
7 0 0000 0834
// Count from the low jaddr bits, loop word is its own body
6 0 1102 0835
7 0 0000 0835
7 0 0000 0835
7 0 0000 0836
// Zero count falls through at once
6 0 0100 0837
7 0 0000 0838
0 0 0000 0839
// Return from an empty stack wraps to the top slot
4 0 0000 0821
0 0 0000 0822

// ==== hw/masel_pkg.sv ====
// Address and count widths, selector code enum, return stack depth and pointer type

package masel_pkg;

  // Microaddress width, 8K words of control store
  localparam int UADDR_W = 13;

  // Repeat count taken from the low jump field bits
  localparam int REP_CNT_W = 8;

  // Return stack geometry
  localparam int STACK_DEPTH = 4;
  localparam int SP_W        = $clog2(STACK_DEPTH);

  // Microinstruction address
  typedef logic [UADDR_W-1:0] uaddr_t;

  // Repeat loop count
  typedef logic [REP_CNT_W-1:0] rep_cnt_t;

  // Return stack pointer, wraps at STACK_DEPTH
  typedef logic [SP_W-1:0] sp_t;

  // Next address source selector
  typedef enum logic [2:0] {
    SEL_NEXT     = 3'd0, // ma + 1
    SEL_JUMP     = 3'd1, // Jump field
    SEL_JCOND    = 3'd2, // Jump field if cond, else ma + 1
    SEL_CALL     = 3'd3, // Jump field, push ma + 1
    SEL_RET      = 3'd4, // Pop return address
    SEL_HOLD     = 3'd5, // Stay put
    SEL_RPT_SET  = 3'd6, // Load count and loop start
    SEL_RPT_LOOP = 3'd7  // Back to loop start while count nonzero
  } sel_t;

endpackage

// ==== hw/masel_repeat.sv ====
// Repeat unit with loop start register, loop counter and loop-taken decision
`timescale 1ns/1ns

module masel_repeat (
  input  logic                s_mclk,
  input  logic                arst_n,
  input  logic                rep_load,  // Capture count and start
  input  logic                rep_step,  // Count one loop pass
  input  logic                loop_req,  // Selector asks for a loop step
  input  masel_pkg::rep_cnt_t cnt_in,    // New count from jump field
  input  masel_pkg::uaddr_t   start_in,  // Loop start, address after the set
  output masel_pkg::uaddr_t   rep_addr,  // Loop start address
  output logic                rep_taken  // Loop goes back this cycle
);

  masel_pkg::rep_cnt_t rep_cnt;   // Remaining passes
  masel_pkg::uaddr_t   rep_start; // Loop start register
  logic                cnt_zero;

  // Loop count register
  always_ff @(posedge s_mclk or negedge arst_n) begin
    if (!arst_n) begin
      rep_cnt <= '0;
    end else if (rep_load) begin
      rep_cnt <= cnt_in;
    end else if (rep_step && rep_taken) begin
      rep_cnt <= rep_cnt - masel_pkg::rep_cnt_t'(1); // One pass used
    end
  end

  // Loop start register
  // Only changes on a new set
  always_ff @(posedge s_mclk or negedge arst_n) begin
    if (!arst_n) begin
      rep_start <= '0;
    end else if (rep_load) begin
      rep_start <= start_in;
    end
  end

  // The only zero test of the count in the design
  assign cnt_zero = (rep_cnt == '0);

  // Taken while passes remain, falls through at zero
  assign rep_taken = loop_req & ~cnt_zero;
  assign rep_addr  = rep_start;

endmodule

// ==== hw/masel_select.sv ====
// Next-address multiplexer with stack and repeat strobe decode
`timescale 1ns/1ns

module masel_select (
  input  masel_pkg::sel_t     sel,       // Selector code from microword
  input  logic                cond,      // Condition bit for SEL_JCOND
  input  masel_pkg::uaddr_t   jaddr,     // Jump field
  input  masel_pkg::uaddr_t   ma,        // Current address
  input  masel_pkg::uaddr_t   ma_inc,    // Current address + 1
  input  masel_pkg::uaddr_t   stack_top, // Return address
  input  masel_pkg::uaddr_t   rep_addr,  // Loop start
  input  logic                rep_taken, // Repeat unit says loop back
  output masel_pkg::uaddr_t   next_ma,
  output logic                push,
  output logic                pop,
  output masel_pkg::uaddr_t   push_data,
  output logic                rep_load,
  output logic                rep_step,
  output logic                loop_req,
  output masel_pkg::rep_cnt_t rep_cnt
);

  // Loop request straight from the code
  // Kept outside the mux so rep_taken has no path back into it
  assign loop_req = (sel == masel_pkg::SEL_RPT_LOOP);

  // Calls save the following address
  assign push_data = ma_inc;

  // Count comes from the low jump field bits
  assign rep_cnt = jaddr[masel_pkg::REP_CNT_W-1:0];

  // Address mux and strobe decode
  always_comb begin
    next_ma  = ma_inc; // Default is sequential
    push     = 1'b0;
    pop      = 1'b0;
    rep_load = 1'b0;
    rep_step = 1'b0;
    case (sel)
      masel_pkg::SEL_NEXT: next_ma = ma_inc;
      masel_pkg::SEL_JUMP: next_ma = jaddr;
      masel_pkg::SEL_JCOND: begin
        if (cond) begin
          next_ma = jaddr; // Taken branch
        end
      end
      masel_pkg::SEL_CALL: begin
        next_ma = jaddr;
        push    = 1'b1;
      end
      masel_pkg::SEL_RET: begin
        next_ma = stack_top;
        pop     = 1'b1;
      end
      masel_pkg::SEL_HOLD: next_ma = ma; // Wait in place
      masel_pkg::SEL_RPT_SET: rep_load = 1'b1; // Body starts at ma + 1
      masel_pkg::SEL_RPT_LOOP: begin
        // Repeat unit owns the decision
        if (rep_taken) begin
          next_ma  = rep_addr;
          rep_step = 1'b1;
        end
      end
      default: next_ma = ma_inc;
    endcase
  end

endmodule

// ==== hw/masel_stack.sv ====
// Four-entry circular return address stack with push and pop
`timescale 1ns/1ns

module masel_stack (
  input  logic              s_mclk,
  input  logic              arst_n,
  input  logic              push,      // Call strobe
  input  logic              pop,       // Return strobe
  input  masel_pkg::uaddr_t push_data, // Return address to save
  output masel_pkg::uaddr_t stack_top  // Entry below the pointer
);

  // Return address entries
  masel_pkg::uaddr_t stack_mem [masel_pkg::STACK_DEPTH];

  // Points at the next free slot
  masel_pkg::sp_t sp;
  masel_pkg::sp_t sp_below;

  // Pointer update
  // Wraps both ways, no full or empty flags
  always_ff @(posedge s_mclk or negedge arst_n) begin
    if (!arst_n) begin
      sp <= '0;
    end else if (push) begin
      sp <= sp + masel_pkg::sp_t'(1); // Advance past written slot
    end else if (pop) begin
      sp <= sp_below;                 // Step back to last entry
    end
  end

  // Entry writes
  // Fifth push lands on the oldest entry
  always_ff @(posedge s_mclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < masel_pkg::STACK_DEPTH; i++) begin
        stack_mem[i] <= '0;
      end
    end else if (push) begin
      stack_mem[sp] <= push_data;
    end
  end

  // Last written slot
  assign sp_below = sp - masel_pkg::sp_t'(1);

  // Popped value is visible before the pop edge
  // Empty stack just wraps to the top slot
  assign stack_top = stack_mem[sp_below];

endmodule

// ==== hw/masel_top.sv ====
// Microprogram address selector top with counter, repeat unit, stack and mux
`timescale 1ns/1ns

module masel_top (
  input  logic              s_mclk,
  input  logic              arst_n,
  input  masel_pkg::sel_t   sel,   // Next address source
  input  logic              cond,  // Branch condition
  input  masel_pkg::uaddr_t jaddr, // Jump field
  output masel_pkg::uaddr_t ma     // Current microaddress
);

  masel_pkg::uaddr_t   next_ma;
  masel_pkg::uaddr_t   ma_inc;
  masel_pkg::uaddr_t   stack_top;
  masel_pkg::uaddr_t   push_data;
  masel_pkg::uaddr_t   rep_addr;
  masel_pkg::rep_cnt_t rep_cnt;
  logic                push;
  logic                pop;
  logic                rep_load;
  logic                rep_step;
  logic                rep_taken;
  logic                loop_req;

  // Address register, the only cycle of latency
  masel_upc u_upc (
    .s_mclk  (s_mclk),
    .arst_n  (arst_n),
    .next_ma (next_ma),
    .ma      (ma),
    .ma_inc  (ma_inc)
  );

  // Counted loops
  masel_repeat u_repeat (
    .s_mclk    (s_mclk),
    .arst_n    (arst_n),
    .rep_load  (rep_load),
    .rep_step  (rep_step),
    .loop_req  (loop_req),
    .cnt_in    (rep_cnt),
    .start_in  (ma_inc),    // Loop body follows the set word
    .rep_addr  (rep_addr),
    .rep_taken (rep_taken)
  );

  // Subroutine return addresses
  masel_stack u_stack (
    .s_mclk    (s_mclk),
    .arst_n    (arst_n),
    .push      (push),
    .pop       (pop),
    .push_data (push_data),
    .stack_top (stack_top)
  );

  // Combinational source select
  masel_select u_select (
    .sel       (sel),
    .cond      (cond),
    .jaddr     (jaddr),
    .ma        (ma),
    .ma_inc    (ma_inc),
    .stack_top (stack_top),
    .rep_addr  (rep_addr),
    .rep_taken (rep_taken),
    .next_ma   (next_ma),
    .push      (push),
    .pop       (pop),
    .push_data (push_data),
    .rep_load  (rep_load),
    .rep_step  (rep_step),
    .loop_req  (loop_req),
    .rep_cnt   (rep_cnt)
  );

endmodule

// ==== hw/masel_upc.sv ====
// Microprogram counter register with combinational incrementer
`timescale 1ns/1ns

module masel_upc (
  input  logic              s_mclk,
  input  logic              arst_n,
  input  masel_pkg::uaddr_t next_ma, // Selected next address
  output masel_pkg::uaddr_t ma,      // Current microaddress
  output masel_pkg::uaddr_t ma_inc   // ma + 1
);

  // Microaddress register
  // Loaded every clock, no enable
  always_ff @(posedge s_mclk or negedge arst_n) begin
    if (!arst_n) begin
      ma <= '0; // Start of microprogram
    end else begin
      ma <= next_ma;
    end
  end

  // Incrementer, wraps 1FFF -> 0
  assign ma_inc = ma + masel_pkg::uaddr_t'(1);

endmodule

// ==== masel_top.f ====
hw/masel_pkg.sv
hw/masel_upc.sv
hw/masel_repeat.sv
hw/masel_stack.sv
hw/masel_select.sv
hw/masel_top.sv
bench/masel_tb.sv
